/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

  // register counts
  localparam int num_arch = 32;
  localparam int num_preg = 64;
  localparam int num_free = num_preg - num_arch;  // pregs left unmapped after reset
  localparam int num_rob  = 16;

  localparam int zero_reg = 31;  // commit write dropped for this index

  // field widths
  localparam int arch_w = $clog2(num_arch);
  localparam int preg_w = $clog2(num_preg);
  localparam int rob_w  = $clog2(num_rob);
  localparam int word_w = 64;

  typedef logic [arch_w-1:0] arch_idx_t;
  typedef logic [preg_w-1:0] preg_t;
  typedef logic [rob_w-1:0]  rob_idx_t;
  typedef logic [word_w-1:0] word_t;

  // free list pointers wrap on their own, count needs one more bit
  typedef logic [$clog2(num_free)-1:0]   free_idx_t;
  typedef logic [$clog2(num_free+1)-1:0] free_cnt_t;

  // rob occupancy, 0 to num_rob
  typedef logic [$clog2(num_rob+1)-1:0] rob_cnt_t;

endpackage

`default_nettype wire

/* verilog/packet_pkg.sv */
`default_nettype none

package packet_pkg;

  // instruction entering the core
  typedef struct packed {
    core_pkg::arch_idx_t arch_dest;
    core_pkg::word_t     npc;
    logic                halt;
    logic                illegal;
  } dispatch_t;

  // finished result, tagged with its rob slot
  typedef struct packed {
    core_pkg::rob_idx_t rob_tag;
    core_pkg::word_t    value;
  } complete_t;

  // rename result handed to the rob
  typedef struct packed {
    core_pkg::arch_idx_t arch_dest;
    core_pkg::preg_t     new_preg;
    core_pkg::preg_t     old_preg;  // freed when this one retires
    core_pkg::word_t     npc;
    logic                halt;
    logic                illegal;
  } rename_t;

  // retired instruction on the commit port
  typedef struct packed {
    core_pkg::arch_idx_t arch_dest;
    core_pkg::word_t     wr_data;
    logic                wr_en;
    core_pkg::preg_t     preg;
    core_pkg::word_t     npc;
  } commit_t;

  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_t;

endpackage

`default_nettype wire

/* verilog/req_ack_sink.sv */
`timescale 1ns/1ns
`default_nettype none

module req_ack_sink #(
  parameter type payload_t = logic
) (
  input  wire           clock,
  input  wire           arst_n,
  input  wire           req,         // four-phase request from the sender
  input  wire payload_t payload_in,  // held stable by the sender while req is high
  input  wire           take,        // one-cycle pulse from the consumer
  output logic          ack,
  output logic          valid,
  output payload_t      payload
);

  // handshake control
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ack   <= 1'b0;
      valid <= 1'b0;
    end else begin
      if (req && !ack && !valid) begin
        valid <= 1'b1;  // new request seen
      end else if (valid && take) begin
        valid <= 1'b0;
        ack   <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;    // return to zero
      end
    end
  end

  // payload capture, only on a fresh request
  always_ff @(posedge clock) begin
    if (req && !ack && !valid) begin
      payload <= payload_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/rename_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_unit (
  input  wire                        clock,
  input  wire                        arst_n,
  input  wire                        dispatch_valid,
  input  wire packet_pkg::dispatch_t dispatch,
  input  wire                        rob_ready,
  input  wire                        release_en,    // rob retired an entry
  input  wire core_pkg::preg_t       release_preg,  // its old mapping
  output logic                       dispatch_take,
  output logic                       push,
  output packet_pkg::rename_t        renamed
);

  core_pkg::preg_t     map_table [core_pkg::num_arch];
  core_pkg::preg_t     free_list [core_pkg::num_free];
  core_pkg::free_idx_t free_head;
  core_pkg::free_idx_t free_tail;
  core_pkg::free_cnt_t free_count;

  // a preg and a rob slot are both needed to accept
  assign dispatch_take = dispatch_valid && (free_count != '0) && rob_ready;
  assign push          = dispatch_take;

  always_comb begin
    renamed.arch_dest = dispatch.arch_dest;
    renamed.new_preg  = free_list[free_head];
    renamed.old_preg  = map_table[dispatch.arch_dest];
    renamed.npc       = dispatch.npc;
    renamed.halt      = dispatch.halt;
    renamed.illegal   = dispatch.illegal;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      // identity map, spare pregs queued in order
      for (int i = 0; i < core_pkg::num_arch; i++) begin
        map_table[i] <= core_pkg::preg_t'(i);
      end
      for (int i = 0; i < core_pkg::num_free; i++) begin
        free_list[i] <= core_pkg::preg_t'(core_pkg::num_arch + i);
      end
      free_head  <= '0;
      free_tail  <= '0;
      free_count <= core_pkg::free_cnt_t'(core_pkg::num_free);
    end else begin
      if (dispatch_take) begin
        map_table[dispatch.arch_dest] <= free_list[free_head];
        free_head <= free_head + core_pkg::free_idx_t'(1);
      end
      if (release_en) begin
        free_list[free_tail] <= release_preg;  // append at tail
        free_tail <= free_tail + core_pkg::free_idx_t'(1);
      end

      case ({dispatch_take, release_en})
        2'b10:   free_count <= free_count - core_pkg::free_cnt_t'(1);
        2'b01:   free_count <= free_count + core_pkg::free_cnt_t'(1);
        default: free_count <= free_count;  // none, or one in and one out
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
  input  wire                        clock,
  input  wire                        arst_n,
  input  wire                        push,
  input  wire packet_pkg::rename_t   renamed,
  input  wire                        complete_valid,
  input  wire packet_pkg::complete_t complete,
  input  wire                        pop,           // head accepted by the commit port
  output logic                       rob_ready,
  output logic                       complete_take,
  output logic                       head_valid,
  output packet_pkg::commit_t        head,
  output logic                       release_en,
  output core_pkg::preg_t            release_preg,
  output packet_pkg::error_t         error_status
);

  packet_pkg::rename_t        info  [core_pkg::num_rob];
  core_pkg::word_t            value [core_pkg::num_rob];
  logic [core_pkg::num_rob-1:0] done;
  core_pkg::rob_idx_t         rob_head;
  core_pkg::rob_idx_t         rob_tail;
  core_pkg::rob_cnt_t         rob_count;

  assign rob_ready     = rob_count != core_pkg::rob_cnt_t'(core_pkg::num_rob);
  assign complete_take = complete_valid;  // a slot always exists for a completion

  // head waits for its result, and nothing leaves after a stop
  assign head_valid = done[rob_head] && (error_status == packet_pkg::no_error);

  always_comb begin
    head.arch_dest = info[rob_head].arch_dest;
    head.wr_data   = value[rob_head];
    head.wr_en     = info[rob_head].arch_dest != core_pkg::arch_idx_t'(core_pkg::zero_reg);
    head.preg      = info[rob_head].new_preg;
    head.npc       = info[rob_head].npc;
  end

  assign release_en   = pop;
  assign release_preg = info[rob_head].old_preg;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      done         <= '0;
      rob_head     <= '0;
      rob_tail     <= '0;
      rob_count    <= '0;
      error_status <= packet_pkg::no_error;
    end else begin
      if (push) begin
        done[rob_tail] <= 1'b0;
        rob_tail       <= rob_tail + core_pkg::rob_idx_t'(1);
      end
      if (complete_take) begin
        done[complete.rob_tag] <= 1'b1;
      end
      if (pop) begin
        done[rob_head] <= 1'b0;
        rob_head       <= rob_head + core_pkg::rob_idx_t'(1);
        // halt wins when both bits are set
        if (info[rob_head].halt) begin
          error_status <= packet_pkg::halted_on_halt;
        end else if (info[rob_head].illegal) begin
          error_status <= packet_pkg::halted_on_illegal;
        end
      end

      case ({push, pop})
        2'b10:   rob_count <= rob_count + core_pkg::rob_cnt_t'(1);
        2'b01:   rob_count <= rob_count - core_pkg::rob_cnt_t'(1);
        default: rob_count <= rob_count;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (push) begin
      info[rob_tail] <= renamed;
    end
    if (complete_take) begin
      value[complete.rob_tag] <= complete.value;
    end
  end

endmodule

`default_nettype wire

/* verilog/commit_port.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_port (
  input  wire                      clock,
  input  wire                      arst_n,
  input  wire                      head_valid,
  input  wire packet_pkg::commit_t head,
  input  wire                      commit_ack,
  output logic                     pop,
  output logic                     commit_req,
  output packet_pkg::commit_t      commit,           // held while req is up
  output core_pkg::word_t          completed_insts
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_low
  } state_t;

  state_t state;

  assign pop        = (state == st_idle) && head_valid;
  assign commit_req = state == st_request;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state           <= st_idle;
      completed_insts <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            state           <= st_request;
            completed_insts <= completed_insts + core_pkg::word_t'(1);
          end
        end
        st_request:  if (commit_ack) state <= st_wait_low;   // req drops here
        st_wait_low: if (!commit_ack) state <= st_idle;
        default:     state <= st_idle;
      endcase
    end
  end

  // holding register for the record on the port
  always_ff @(posedge clock) begin
    if (pop) begin
      commit <= head;
    end
  end

endmodule

`default_nettype wire

/* verilog/rename_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_core (
  input  wire                        clock,
  input  wire                        arst_n,
  input  wire                        dispatch_req,
  input  wire packet_pkg::dispatch_t dispatch,
  output logic                       dispatch_ack,
  input  wire                        complete_req,
  input  wire packet_pkg::complete_t complete,
  output logic                       complete_ack,
  output logic                       commit_req,
  output packet_pkg::commit_t        commit,
  input  wire                        commit_ack,
  output core_pkg::word_t            completed_insts,  // retired count
  output packet_pkg::error_t         error_status
);

  logic                  dispatch_valid;
  logic                  dispatch_take;
  packet_pkg::dispatch_t dispatch_q;
  logic                  complete_valid;
  logic                  complete_take;
  packet_pkg::complete_t complete_q;
  logic                  rob_ready;
  logic                  push;
  packet_pkg::rename_t   renamed;
  logic                  head_valid;
  packet_pkg::commit_t   head;
  logic                  pop;
  logic                  release_en;
  core_pkg::preg_t       release_preg;

  req_ack_sink #(.payload_t(packet_pkg::dispatch_t)) dispatch_sink_0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .req        (dispatch_req),
    .payload_in (dispatch),
    .take       (dispatch_take),
    .ack        (dispatch_ack),
    .valid      (dispatch_valid),
    .payload    (dispatch_q)
  );

  // results may come back in any order
  req_ack_sink #(.payload_t(packet_pkg::complete_t)) complete_sink_0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .req        (complete_req),
    .payload_in (complete),
    .take       (complete_take),
    .ack        (complete_ack),
    .valid      (complete_valid),
    .payload    (complete_q)
  );

  rename_unit rename_unit_0 (
    .clock          (clock),
    .arst_n         (arst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch_q),
    .rob_ready      (rob_ready),
    .release_en     (release_en),
    .release_preg   (release_preg),
    .dispatch_take  (dispatch_take),
    .push           (push),
    .renamed        (renamed)
  );

  reorder_buffer reorder_buffer_0 (
    .clock          (clock),
    .arst_n         (arst_n),
    .push           (push),
    .renamed        (renamed),
    .complete_valid (complete_valid),
    .complete       (complete_q),
    .pop            (pop),
    .rob_ready      (rob_ready),
    .complete_take  (complete_take),
    .head_valid     (head_valid),
    .head           (head),
    .release_en     (release_en),
    .release_preg   (release_preg),
    .error_status   (error_status)
  );

  commit_port commit_port_0 (
    .clock           (clock),
    .arst_n          (arst_n),
    .head_valid      (head_valid),
    .head            (head),
    .commit_ack      (commit_ack),
    .pop             (pop),
    .commit_req      (commit_req),
    .commit          (commit),
    .completed_insts (completed_insts)
  );

endmodule

`default_nettype wire

/* tests/tb_rename_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rename_core;

  localparam int num_rows    = 24;
  localparam int cycle_limit = 40 * num_rows + 200;

  typedef struct packed {
    logic [4:0]  arch_dest;
    logic [63:0] npc;
    logic [63:0] value;
    logic        halt;
    logic        illegal;
    logic [1:0]  slot;  // completion order within its group of four
  } row_t;

  logic                  clock = 1'b0;
  logic                  arst_n;
  logic                  dispatch_req;
  packet_pkg::dispatch_t dispatch;
  logic                  dispatch_ack;
  logic                  complete_req;
  packet_pkg::complete_t complete;
  logic                  complete_ack;
  logic                  commit_req;
  packet_pkg::commit_t   commit;
  logic                  commit_ack;
  core_pkg::word_t       completed_insts;
  packet_pkg::error_t    error_status;

  row_t               table_rows [num_rows];
  core_pkg::preg_t    ref_map    [core_pkg::num_arch];  // reference rename map
  core_pkg::preg_t    free_q     [$];
  core_pkg::preg_t    exp_preg   [num_rows];
  core_pkg::preg_t    exp_old    [num_rows];
  int                 exp_commits;
  packet_pkg::error_t exp_error;
  int                 dispatch_count = 0;
  int                 commit_count   = 0;
  int                 check_count    = 0;
  int                 fail_count     = 0;
  int                 row_errs       = 0;
  int                 cycle_count    = 0;
  integer             seed           = 32'hc87f;

  rename_core i_dut (
    .clock           (clock),
    .arst_n          (arst_n),
    .dispatch_req    (dispatch_req),
    .dispatch        (dispatch),
    .dispatch_ack    (dispatch_ack),
    .complete_req    (complete_req),
    .complete        (complete),
    .complete_ack    (complete_ack),
    .commit_req      (commit_req),
    .commit          (commit),
    .commit_ack      (commit_ack),
    .completed_insts (completed_insts),
    .error_status    (error_status)
  );

  always #2 clock = ~clock;

  // watchdog
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic set_row(input int r, input logic [4:0] dest, input logic [63:0] npc,
                         input logic [63:0] value, input logic halt, input logic illegal,
                         input logic [1:0] slot);
    table_rows[r] = '{dest, npc, value, halt, illegal, slot};
  endtask

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, expected);
      fail_count++;
      row_errs++;
    end
  endtask

  // four-phase send of one row with the model updated at the ack
  task automatic send_dispatch(input int r);
    core_pkg::preg_t new_preg;
    @(posedge clock);
    #1;
    dispatch.arch_dest = table_rows[r].arch_dest;
    dispatch.npc       = table_rows[r].npc;
    dispatch.halt      = table_rows[r].halt;
    dispatch.illegal   = table_rows[r].illegal;
    dispatch_req       = 1'b1;
    while (!dispatch_ack) begin
      @(posedge clock);
      #1;
    end
    new_preg = free_q.pop_front();
    exp_preg[r] = new_preg;
    exp_old[r]  = ref_map[table_rows[r].arch_dest];
    ref_map[table_rows[r].arch_dest] = new_preg;
    dispatch_count++;
    dispatch_req = 1'b0;
    while (dispatch_ack) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic send_complete(input int r);
    @(posedge clock);
    #1;
    complete.rob_tag = core_pkg::rob_idx_t'(r % 16);
    complete.value   = table_rows[r].value;
    complete_req     = 1'b1;
    while (!complete_ack) begin
      @(posedge clock);
      #1;
    end
    complete_req = 1'b0;
    while (complete_ack) begin
      @(posedge clock);
      #1;
    end
  endtask

  // first ack held back until dispatch stalls behind a full rob
  task automatic hold_until_rob_full();
    while (dispatch_count < core_pkg::num_rob + 1) begin
      @(posedge clock);
      #1;
    end
    repeat (8) begin
      @(posedge clock);
      #1;
    end
    row_errs = 0;
    // one more row sits in the commit port
    compare_field("rows accepted with rob full", 64'(dispatch_count),
                  64'(core_pkg::num_rob + 1));
    if (row_errs == 0) $display("rob full stall: ok");
    else $display("rob full stall: %0d errors", row_errs);
  endtask

  // commit side checks each record and answers after a random delay
  initial begin
    int delay;
    int r;
    commit_ack = 1'b0;
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clock);
      #1;
      if (commit_req) begin
        r = commit_count;
        if (r >= exp_commits) begin
          $display("commit of npc %h arrived after retirement should have stopped",
                   commit.npc);
          check_count++;
          fail_count++;
        end else begin
          row_errs = 0;
          compare_field("commit.arch_dest", 64'(commit.arch_dest),
                        64'(table_rows[r].arch_dest));
          compare_field("commit.npc", commit.npc, table_rows[r].npc);
          compare_field("commit.wr_data", commit.wr_data, table_rows[r].value);
          compare_field("commit.wr_en", 64'(commit.wr_en),
                        64'(table_rows[r].arch_dest != 5'd31));
          compare_field("commit.preg", 64'(commit.preg), 64'(exp_preg[r]));
          if (row_errs == 0) $display("row %0d commit: ok", r);
          else $display("row %0d commit: %0d errors", r, row_errs);
          free_q.push_back(exp_old[r]);  // old mapping returns at retire
          if (r == 0) hold_until_rob_full();
        end
        commit_count++;
        delay = $unsigned($random(seed)) % 12;
        repeat (delay) begin
          @(posedge clock);
          #1;
        end
        commit_ack = 1'b1;
        while (commit_req) begin
          @(posedge clock);
          #1;
        end
        commit_ack = 1'b0;
      end
    end
  end

  initial begin
    dispatch_req = 1'b0;
    dispatch     = '0;
    complete_req = 1'b0;
    complete     = '0;
    arst_n       = 1'b0;

    set_row( 0, 5'd1,  64'h1000, 64'ha5a5_0000_0000_0001, 1'b0, 1'b0, 2'd2);
    set_row( 1, 5'd2,  64'h1004, 64'h0000_1234_5678_9abc, 1'b0, 1'b0, 2'd0);
    set_row( 2, 5'd3,  64'h1008, 64'hffff_ffff_ffff_fffe, 1'b0, 1'b0, 2'd3);
    set_row( 3, 5'd31, 64'h100c, 64'hdead_beef_0000_0003, 1'b0, 1'b0, 2'd1);
    set_row( 4, 5'd1,  64'h1010, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0, 2'd3);
    set_row( 5, 5'd4,  64'h1014, 64'h8000_0000_0000_0000, 1'b0, 1'b0, 2'd2);
    set_row( 6, 5'd2,  64'h1018, 64'h0000_0000_0000_0006, 1'b0, 1'b0, 2'd1);
    set_row( 7, 5'd5,  64'h101c, 64'h5555_aaaa_5555_aaaa, 1'b0, 1'b0, 2'd0);
    set_row( 8, 5'd0,  64'h1020, 64'h1111_2222_3333_4444, 1'b0, 1'b0, 2'd1);
    set_row( 9, 5'd6,  64'h1024, 64'hc0de_0000_0000_0009, 1'b0, 1'b0, 2'd3);
    set_row(10, 5'd1,  64'h1028, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0, 1'b0, 2'd0);
    set_row(11, 5'd7,  64'h102c, 64'h7777_0000_0000_000b, 1'b0, 1'b0, 2'd2);
    set_row(12, 5'd30, 64'h1030, 64'h0000_0000_ffff_0000, 1'b0, 1'b0, 2'd0);
    set_row(13, 5'd3,  64'h1034, 64'habcd_ef01_2345_6789, 1'b0, 1'b0, 2'd2);
    set_row(14, 5'd31, 64'h1038, 64'hcafe_f00d_0000_000e, 1'b0, 1'b0, 2'd1);
    set_row(15, 5'd2,  64'h103c, 64'h0000_0001_0000_0000, 1'b0, 1'b0, 2'd3);
    set_row(16, 5'd8,  64'h1040, 64'h9999_8888_7777_6666, 1'b0, 1'b0, 2'd2);
    set_row(17, 5'd1,  64'h1044, 64'h0000_0000_0000_0011, 1'b0, 1'b0, 2'd3);
    set_row(18, 5'd9,  64'h1048, 64'h2468_ace0_1357_9bdf, 1'b0, 1'b0, 2'd0);
    set_row(19, 5'd4,  64'h104c, 64'hfedc_ba98_7654_3210, 1'b0, 1'b0, 2'd1);
    set_row(20, 5'd10, 64'h1050, 64'h3c3c_3c3c_0000_0014, 1'b0, 1'b0, 2'd3);
    set_row(21, 5'd11, 64'h1054, 64'h0000_0000_0000_0015, 1'b1, 1'b0, 2'd1);  // halt
    set_row(22, 5'd12, 64'h1058, 64'h6b6b_0000_0000_0016, 1'b0, 1'b0, 2'd0);
    set_row(23, 5'd13, 64'h105c, 64'h0000_0000_0000_0017, 1'b0, 1'b1, 2'd2);  // illegal

    // retirement ends at the first halt or illegal row and halt wins on a tie
    exp_commits = num_rows;
    exp_error   = packet_pkg::no_error;
    for (int r = num_rows - 1; r >= 0; r--) begin
      if (table_rows[r].halt || table_rows[r].illegal) begin
        exp_commits = r + 1;
        exp_error   = table_rows[r].halt ? packet_pkg::halted_on_halt
                                         : packet_pkg::halted_on_illegal;
      end
    end

    for (int i = 0; i < core_pkg::num_arch; i++) ref_map[i] = core_pkg::preg_t'(i);
    for (int i = 0; i < core_pkg::num_free; i++) begin
      free_q.push_back(core_pkg::preg_t'(core_pkg::num_arch + i));
    end

    repeat (10) @(posedge clock);
    #1;
    arst_n = 1'b1;

    fork
      for (int r = 0; r < num_rows; r++) send_dispatch(r);
      // results for a group go out once all four of its rows are in
      for (int g = 0; g < num_rows / 4; g++) begin
        wait (dispatch_count >= g * 4 + 4);
        for (int s = 0; s < 4; s++) begin
          for (int k = 0; k < 4; k++) begin
            if (int'(table_rows[g * 4 + k].slot) == s) send_complete(g * 4 + k);
          end
        end
      end
    join

    while (commit_count < exp_commits) @(posedge clock);
    repeat (30) @(posedge clock);  // room for a stray commit
    #1;

    row_errs = 0;
    compare_field("commit count", 64'(commit_count), 64'(exp_commits));
    compare_field("completed_insts", completed_insts, 64'(commit_count));
    compare_field("error_status", 64'(error_status), 64'(exp_error));
    compare_field("commit_req", 64'(commit_req), 64'd0);
    if (row_errs == 0) $display("stop check: ok");
    else $display("stop check: %0d errors", row_errs);

    $display("summary: %0d checks, %0d failed", check_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/core_pkg.sv
verilog/packet_pkg.sv
verilog/req_ack_sink.sv
verilog/rename_unit.sv
verilog/reorder_buffer.sv
verilog/commit_port.sv
verilog/rename_core.sv
tests/tb_rename_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module tb_rename_core -o sim_tb \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "All checks passed" && exit 0 || exit 1
